/* all.f */
+incdir+.
dehaze_pkg.sv
frame_mem_if.sv
frame_mem.sv
apb_frame_regs.sv
dark_channel_scan.sv
stream_skid.sv
scene_recover.sv
dehaze_top.sv
tb_dehaze_assertions.sv
tb_dehaze.sv

/* apb_frame_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dehaze_settings.svh"

module apb_frame_regs
    import dehaze_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`DH_APB_AW-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    frame_mem_if.host             mem,
    output logic                  start,
    input  logic                  pix_valid,
    input  logic                  pix_ready,
    input  logic                  pix_last
);

    logic      access;
    logic      pix_sel;
    logic      ctrl_sel;
    logic      wr_pix;
    logic      wr_start;
    logic      run_end;
    logic      busy;
    logic      done;
    pix_addr_t pix_addr;
    rgb_t      wr_pixel;

    assign access   = psel && penable;
    assign pix_sel  = paddr < `DH_CTRL_ADDR;
    assign ctrl_sel = paddr == `DH_CTRL_ADDR;
    assign wr_pix   = access && pwrite && pix_sel;
    assign wr_start = access && pwrite && ctrl_sel && pwdata[0];
    assign run_end  = pix_valid && pix_ready && pix_last;   // last pixel taken

    assign pix_addr = paddr[`DH_PIX_AW+1:2];   // word aligned
    assign wr_pixel = pwdata[3*`DH_CH_W-1:0];

    assign mem.wr_en     = wr_pix && !busy;   // frame locked during a run
    assign mem.wr_addr   = pix_addr;
    assign mem.wr_data   = wr_pixel;
    assign mem.host_addr = pix_addr;   // valid from the setup phase on

    assign pready  = 1'b1;
    assign pslverr = busy && (wr_pix || wr_start);

    always_comb begin
        prdata = '0;
        if (ctrl_sel) begin
            prdata[1:0] = {done, busy};
        end else if (pix_sel) begin
            prdata[3*`DH_CH_W-1:0] = mem.host_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= wr_start && !busy;   // single cycle
            if (wr_start && !busy) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (run_end && busy) begin
                busy <= 1'b0;
                done <= 1'b1;   // sticky until next start
            end
        end
    end

endmodule

`default_nettype wire

/* dark_channel_scan.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dehaze_settings.svh"

module dark_channel_scan
    import dehaze_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    frame_mem_if.scan  scan,
    output logic       out_valid,
    output dark_item_t out_item,
    input  logic       out_ready
);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_EMIT} state_t;

    state_t     state;
    pix_addr_t  pix;
    logic [1:0] wx;         // window column 0..2
    logic [1:0] wy;         // window row 0..2
    logic       rd_pend;    // window data arrives this cycle
    logic       ctr_pend;   // centre pixel arrives this cycle
    chan_t      run_min;
    rgb_t       centre;
    rgb_t       sd;
    chan_t      sd_min;
    logic [2:0] px_x;
    logic [2:0] px_y;
    logic       border;
    logic       win_end;

    function automatic chan_t min2(input chan_t a, input chan_t b);
        return (a < b) ? a : b;
    endfunction

    assign px_x   = pix[2:0];
    assign px_y   = pix[5:3];
    assign border = (px_x == 3'd0) || (px_x == 3'(`DH_IMG_DIM - 1)) ||
                    (px_y == 3'd0) || (px_y == 3'(`DH_IMG_DIM - 1));
    assign win_end = (wx == 2'd2) && (wy == 2'd2);

    // border reads only the pixel itself, interior walks the 3x3 window
    assign scan.scan_addr = border ? pix :
                            {px_y + 3'(wy) - 3'd1, px_x + 3'(wx) - 3'd1};

    assign sd     = scan.scan_data;
    assign sd_min = min2(min2(sd.r, sd.g), sd.b);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            pix      <= '0;
            wx       <= '0;
            wy       <= '0;
            rd_pend  <= 1'b0;
            ctr_pend <= 1'b0;
        end else begin
            rd_pend  <= 1'b0;
            ctr_pend <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_READ;
                        pix   <= '0;
                        wx    <= '0;
                        wy    <= '0;
                    end
                end
                S_READ: begin
                    rd_pend  <= !border;
                    ctr_pend <= !border && (wx == 2'd1) && (wy == 2'd1);
                    if (border || win_end) begin
                        state <= S_EMIT;   // address held for the stall
                    end else if (wx == 2'd2) begin
                        wx <= '0;
                        wy <= wy + 2'd1;
                    end else begin
                        wx <= wx + 2'd1;
                    end
                end
                S_EMIT: begin
                    if (out_ready) begin
                        wx <= '0;
                        wy <= '0;
                        if (pix == pix_addr_t'(`DH_NUM_PIX - 1)) begin
                            state <= S_IDLE;
                        end else begin
                            pix   <= pix + 1'b1;
                            state <= S_READ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_READ && wx == 2'd0 && wy == 2'd0) begin
            run_min <= '1;
        end else if (rd_pend) begin
            run_min <= min2(run_min, sd_min);
        end
        if (ctr_pend) begin
            centre <= sd;
        end
    end

    // ninth read lands in the emit cycle, fold it in here
    assign out_valid       = state == S_EMIT;
    assign out_item.pix    = border ? sd : centre;
    assign out_item.dark   = border ? sd_min : min2(run_min, sd_min);
    assign out_item.border = border;
    assign out_item.last   = pix == pix_addr_t'(`DH_NUM_PIX - 1);

endmodule

`default_nettype wire

/* dehaze_pkg.sv */
`default_nettype none

`include "dehaze_settings.svh"

package dehaze_pkg;

    typedef logic [`DH_CH_W-1:0] chan_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // raster address, y*8 + x
    typedef logic [`DH_PIX_AW-1:0] pix_addr_t;

    // scanner to recovery stage
    typedef struct packed {
        rgb_t  pix;
        chan_t dark;     // 3x3 min over all channels
        logic  border;   // pass through untouched
        logic  last;
    } dark_item_t;

    // output stream payload
    typedef struct packed {
        rgb_t pix;
        logic last;
    } out_pix_t;

endpackage

`default_nettype wire

/* dehaze_settings.svh */
`ifndef DEHAZE_SETTINGS_SVH
`define DEHAZE_SETTINGS_SVH

// frame geometry
`define DH_IMG_DIM    8
`define DH_NUM_PIX    64
`define DH_CH_W       8
`define DH_PIX_AW     6

// apb map, pixels sit below the control word
`define DH_APB_AW     9
`define DH_CTRL_ADDR  9'h100

// dark-channel prior constants
`define DH_OMEGA_NUM  3
`define DH_OMEGA_DEN  4
`define DH_ATMOS      255
`define DH_T_SCALE    10   // transmission counted in tenths

`endif

/* dehaze_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dehaze_settings.svh"

module dehaze_top
    import dehaze_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`DH_APB_AW-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  pix_valid,
    input  logic                  pix_ready,
    output logic [`DH_CH_W-1:0]   pix_r,
    output logic [`DH_CH_W-1:0]   pix_g,
    output logic [`DH_CH_W-1:0]   pix_b,
    output logic                  pix_last
);

    logic       start;
    logic       scan_valid;
    logic       scan_ready;
    dark_item_t scan_item;
    logic       dk_valid;
    logic       dk_ready;
    dark_item_t dk_item;
    logic       rec_valid;
    logic       rec_ready;
    out_pix_t   rec_pix;
    out_pix_t   out_data;

    frame_mem_if fm ();

    frame_mem u_mem (.clk(clk), .mem(fm));

    apb_frame_regs u_regs (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .mem(fm), .start(start),
        .pix_valid(pix_valid), .pix_ready(pix_ready), .pix_last(pix_last)
    );

    dark_channel_scan u_scan (
        .clk(clk), .rst(rst), .start(start), .scan(fm),
        .out_valid(scan_valid), .out_item(scan_item), .out_ready(scan_ready)
    );

    stream_skid #(.payload_t(dark_item_t)) dark_skid (
        .clk(clk), .rst(rst), .in_valid(scan_valid), .in_ready(scan_ready),
        .in_data(scan_item), .out_valid(dk_valid), .out_ready(dk_ready),
        .out_data(dk_item)
    );

    scene_recover u_rec (
        .clk(clk), .rst(rst), .in_valid(dk_valid), .in_ready(dk_ready),
        .in_item(dk_item), .out_valid(rec_valid), .out_ready(rec_ready),
        .out_pix(rec_pix)
    );

    stream_skid #(.payload_t(out_pix_t)) out_skid (
        .clk(clk), .rst(rst), .in_valid(rec_valid), .in_ready(rec_ready),
        .in_data(rec_pix), .out_valid(pix_valid), .out_ready(pix_ready),
        .out_data(out_data)
    );

    // flatten the payload onto plain ports
    assign pix_r    = out_data.pix.r;
    assign pix_g    = out_data.pix.g;
    assign pix_b    = out_data.pix.b;
    assign pix_last = out_data.last;

endmodule

`default_nettype wire

/* frame_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dehaze_settings.svh"

module frame_mem
    import dehaze_pkg::*;
(
    input  logic     clk,
    frame_mem_if.mem mem
);

    rgb_t ram [`DH_NUM_PIX];
    rgb_t host_q;
    rgb_t scan_q;

    // single write port, host side only
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    // both reads registered, old data on a same-address write
    always_ff @(posedge clk) begin
        host_q <= ram[mem.host_addr];
        scan_q <= ram[mem.scan_addr];
    end

    assign mem.host_data = host_q;
    assign mem.scan_data = scan_q;

endmodule

`default_nettype wire

/* frame_mem_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dehaze_settings.svh"

interface frame_mem_if;
    logic                  wr_en;
    logic [`DH_PIX_AW-1:0] wr_addr;
    logic [3*`DH_CH_W-1:0] wr_data;
    logic [`DH_PIX_AW-1:0] host_addr;
    logic [3*`DH_CH_W-1:0] host_data;   // one cycle after host_addr
    logic [`DH_PIX_AW-1:0] scan_addr;
    logic [3*`DH_CH_W-1:0] scan_data;   // one cycle after scan_addr

    modport mem (input wr_en, wr_addr, wr_data, host_addr, scan_addr,
                 output host_data, scan_data);

    modport host (output wr_en, wr_addr, wr_data, host_addr,
                  input host_data);

    modport scan (output scan_addr, input scan_data);
endinterface

`default_nettype wire

/* scene_recover.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dehaze_settings.svh"

module scene_recover
    import dehaze_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    output logic       in_ready,
    input  dark_item_t in_item,
    output logic       out_valid,
    input  logic       out_ready,
    output out_pix_t   out_pix
);

    localparam int NUM_W = 12;   // fits 255 * 10
    localparam int T_NUM = `DH_OMEGA_NUM * `DH_T_SCALE;
    localparam int T_DEN = `DH_OMEGA_DEN * `DH_ATMOS;

    typedef enum logic [1:0] {R_IDLE, R_DIV, R_DONE} state_t;

    state_t           state;
    logic [1:0]       ch;      // r, g, b in turn
    logic [3:0]       cnt;     // divider step
    rgb_t             px;
    rgb_t             res;
    logic             last_q;
    logic [3:0]       t;       // tenths, 3..10
    logic [3:0]       rem;
    logic [NUM_W-1:0] nq;      // numerator shifting out, quotient in
    logic [3:0]       t_calc;
    logic [4:0]       rem_sh;
    logic [4:0]       rem_nx;
    logic [NUM_W-1:0] nq_nx;
    chan_t            restored;
    logic             accept;
    logic             ch_done;

    function automatic logic [NUM_W-1:0] num_of(input chan_t c);
        return NUM_W'((`DH_ATMOS - c) * `DH_T_SCALE);
    endfunction

    assign accept  = in_valid && in_ready;
    assign ch_done = cnt == 4'(NUM_W - 1);
    assign t_calc  = 4'(`DH_T_SCALE - T_NUM * in_item.dark / T_DEN);

    // one restoring step per cycle
    always_comb begin
        rem_sh = {rem, nq[NUM_W-1]};
        if (rem_sh >= {1'b0, t}) begin
            rem_nx = rem_sh - {1'b0, t};
            nq_nx  = {nq[NUM_W-2:0], 1'b1};
        end else begin
            rem_nx = rem_sh;
            nq_nx  = {nq[NUM_W-2:0], 1'b0};
        end
        restored = (nq_nx > NUM_W'(`DH_ATMOS)) ? '0 : chan_t'(`DH_ATMOS - nq_nx);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= R_IDLE;
            ch    <= '0;
            cnt   <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (accept) begin
                        state <= in_item.border ? R_DONE : R_DIV;
                        ch    <= '0;
                        cnt   <= '0;
                    end
                end
                R_DIV: begin
                    if (ch_done) begin
                        cnt <= '0;
                        if (ch == 2'd2) state <= R_DONE;
                        else ch <= ch + 2'd1;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                R_DONE: if (out_ready) state <= R_IDLE;
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            px     <= in_item.pix;
            res    <= in_item.pix;   // border keeps this
            last_q <= in_item.last;
            t      <= t_calc;
            rem    <= '0;
            nq     <= num_of(in_item.pix.r);
        end else if (state == R_DIV) begin
            if (ch_done) begin
                case (ch)
                    2'd0:    res.r <= restored;
                    2'd1:    res.g <= restored;
                    default: res.b <= restored;
                endcase
                rem <= '0;
                nq  <= num_of((ch == 2'd0) ? px.g : px.b);
            end else begin
                rem <= rem_nx[3:0];
                nq  <= nq_nx;
            end
        end
    end

    assign in_ready     = state == R_IDLE;
    assign out_valid    = state == R_DONE;
    assign out_pix.pix  = res;
    assign out_pix.last = last_q;

endmodule

`default_nettype wire

/* stream_skid.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_skid
    import dehaze_pkg::*;
#(
    parameter type payload_t = out_pix_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     skid_valid;
    payload_t skid_data;
    logic     main_free;
    logic     take_in;

    assign main_free = out_ready || !out_valid;
    assign in_ready  = !skid_valid;   // straight from a flop
    assign take_in   = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            out_valid  <= skid_valid || take_in;
            skid_valid <= 1'b0;   // skid drains first
        end else if (take_in) begin
            skid_valid <= 1'b1;   // downstream stalled, park it
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (!main_free && take_in) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* tb_dehaze.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dehaze_settings.svh"

module tb_dehaze
    import dehaze_pkg::*;
();

    localparam int          NUM_RUNS   = 8;
    localparam int          RUN_CYCLES = `DH_NUM_PIX * 50;
    localparam int          MARGIN     = 5000;   // apb loads and readback
    localparam logic [31:0] SEED       = 32'h24f8d27b;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`DH_APB_AW-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  pix_valid;
    logic                  pix_ready;
    logic [`DH_CH_W-1:0]   pix_r;
    logic [`DH_CH_W-1:0]   pix_g;
    logic [`DH_CH_W-1:0]   pix_b;
    logic                  pix_last;

    rgb_t frame [`DH_NUM_PIX];      // what the host loads
    rgb_t expected [`DH_NUM_PIX];   // model output in raster order

    dehaze_top dut (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .pix_valid(pix_valid), .pix_ready(pix_ready),
        .pix_r(pix_r), .pix_g(pix_g), .pix_b(pix_b), .pix_last(pix_last)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (NUM_RUNS * RUN_CYCLES + MARGIN) @(posedge clk);
        $display("timeout: the pixel stream did not complete in the allowed cycles");
        $display("Test failures found");
        $fatal(1);
    end

    initial begin
        wait (dut.u_assert.fail_cnt != 0);
        $display("a protocol assertion on the apb bus or the pixel stream failed");
        $display("Test failures found");
        $fatal(1);
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0.1f ns: %s = 0x%0h, expected 0x%0h",
                     $realtime, name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic apb_write(input logic [`DH_APB_AW-1:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge clk);
        psel    = 1'b1;   // setup phase
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`DH_APB_AW-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        data = prdata;   // valid in the access phase
        compare("pready", pready, 32'd1);
        compare("pslverr", pslverr, 32'd0);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic [`DH_APB_AW-1:0] pix_addr_of(input int idx);
        return `DH_APB_AW'(idx * 4);
    endfunction

    // channels drawn from lo..255
    task automatic fill_frame(input int lo);
        for (int i = 0; i < `DH_NUM_PIX; i++) begin
            frame[i].r = chan_t'(lo + $urandom % (256 - lo));
            frame[i].g = chan_t'(lo + $urandom % (256 - lo));
            frame[i].b = chan_t'(lo + $urandom % (256 - lo));
        end
    endtask

    task automatic load_frame();
        logic err;
        for (int i = 0; i < `DH_NUM_PIX; i++) begin
            apb_write(pix_addr_of(i), {8'h00, frame[i]}, err);
            compare("pslverr", err, 32'd0);
        end
    endtask

    function automatic int tenths(input int d);
        return `DH_T_SCALE - (`DH_OMEGA_NUM * `DH_T_SCALE * d) / (`DH_OMEGA_DEN * `DH_ATMOS);
    endfunction

    function automatic int restore_chan(input int c, input int t);
        int v;
        v = `DH_ATMOS - ((`DH_ATMOS - c) * `DH_T_SCALE) / t;
        return (v < 0) ? 0 : v;
    endfunction

    function automatic int dark_at(input int x, input int y);
        int   m;
        rgb_t p;
        m = 255;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                p = frame[(y + dy) * `DH_IMG_DIM + x + dx];
                if (p.r < m) m = p.r;
                if (p.g < m) m = p.g;
                if (p.b < m) m = p.b;
            end
        end
        return m;
    endfunction

    task automatic build_expected();
        int x;
        int y;
        int t;
        for (int i = 0; i < `DH_NUM_PIX; i++) begin
            x = i % `DH_IMG_DIM;
            y = i / `DH_IMG_DIM;
            expected[i] = frame[i];   // border stays as loaded
            if (x > 0 && x < `DH_IMG_DIM - 1 && y > 0 && y < `DH_IMG_DIM - 1) begin
                t = tenths(dark_at(x, y));
                expected[i].r = chan_t'(restore_chan(frame[i].r, t));
                expected[i].g = chan_t'(restore_chan(frame[i].g, t));
                expected[i].b = chan_t'(restore_chan(frame[i].b, t));
            end
        end
    endtask

    task automatic start_run();
        logic err;
        apb_write(`DH_CTRL_ADDR, 32'd1, err);
        compare("pslverr", err, 32'd0);
    endtask

    task automatic collect_frame();
        int          idx;
        logic [31:0] status;
        idx = 0;
        while (idx < `DH_NUM_PIX) begin
            @(negedge clk);
            pix_ready = ($urandom % 10) >= 3;   // roughly 30 % stall
            @(posedge clk);
            if (pix_valid && pix_ready) begin
                compare($sformatf("pix_r[%0d]", idx), pix_r, expected[idx].r);
                compare($sformatf("pix_g[%0d]", idx), pix_g, expected[idx].g);
                compare($sformatf("pix_b[%0d]", idx), pix_b, expected[idx].b);
                compare($sformatf("pix_last[%0d]", idx), pix_last, idx == `DH_NUM_PIX - 1);
                idx++;
            end
        end
        @(negedge clk);
        pix_ready = 1'b0;
        apb_read(`DH_CTRL_ADDR, status);
        compare("status", status, 32'h2);   // busy 0 and done 1
        compare("pix_valid", pix_valid, 32'd0);
    endtask

    task automatic run_frame();
        build_expected();
        load_frame();
        start_run();
        collect_frame();
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        rd = $urandom(SEED);
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pix_ready = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        compare("pix_valid", pix_valid, 32'd0);
        apb_read(`DH_CTRL_ADDR, rd);
        compare("status", rd, 32'd0);

        // load then read every pixel back
        fill_frame(0);
        load_frame();
        for (int i = 0; i < `DH_NUM_PIX; i++) begin
            apb_read(pix_addr_of(i), rd);
            compare($sformatf("prdata[%0d]", i), rd, {8'h00, frame[i]});
        end
        build_expected();
        start_run();
        collect_frame();

        for (int i = 0; i < `DH_NUM_PIX; i++) frame[i] = '1;   // t = 3
        run_frame();
        for (int i = 0; i < `DH_NUM_PIX; i++) frame[i] = '0;   // t = 10
        run_frame();
        for (int i = 0; i < `DH_NUM_PIX; i++) frame[i] = {8'd200, 8'd200, 8'd200};
        frame[3 * `DH_IMG_DIM + 4] = '0;   // dark spot reaching its 3x3 ring
        run_frame();

        // frame and start locked while busy
        fill_frame(100);
        build_expected();
        load_frame();
        start_run();
        apb_read(`DH_CTRL_ADDR, rd);
        compare("status", rd, 32'h1);
        apb_write(pix_addr_of(27), 32'h0012_3456, err);
        compare("pslverr", err, 32'd1);
        apb_write(`DH_CTRL_ADDR, 32'd1, err);
        compare("pslverr", err, 32'd1);
        collect_frame();
        apb_read(pix_addr_of(27), rd);
        compare("prdata[27]", rd, {8'h00, frame[27]});

        for (int n = 0; n < 3; n++) begin
            fill_frame(n * 90);
            run_frame();
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_dehaze_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dehaze_settings.svh"

module tb_dehaze_assertions (
    input logic                clk,
    input logic                rst,
    input logic                psel,
    input logic                penable,
    input logic                pslverr,
    input logic                pix_valid,
    input logic                pix_ready,
    input logic [`DH_CH_W-1:0] pix_r,
    input logic [`DH_CH_W-1:0] pix_g,
    input logic [`DH_CH_W-1:0] pix_b,
    input logic                pix_last
);

    int fail_cnt = 0;   // assertion failures so far

    // stalled output keeps valid and payload
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        pix_valid && !pix_ready |=> pix_valid && $stable({pix_r, pix_g, pix_b, pix_last}))
        else begin
            fail_cnt++;
            $error("pixel stream changed while stalled");
        end

    a_slverr_access: assert property (@(posedge clk) pslverr |-> psel && penable)
        else begin
            fail_cnt++;
            $error("pslverr outside an apb access phase");
        end

    a_reset_quiet: assert property (@(posedge clk) rst |-> !pix_valid)
        else begin
            fail_cnt++;
            $error("pix_valid high during reset");
        end

endmodule

bind dehaze_top tb_dehaze_assertions u_assert (.*);

`default_nettype wire
